// File: rv_exec_consts.svh
/*
 * Shared constants for the RV64I execute stage
 *   datapath and instruction widths
 *   major opcode values
 *   funct3 codes for OP and OP-IMM
 */
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// Datapath widths
`define XLEN   64
`define INSN_W 32

// --------------------------------------------------
// Major opcodes, insn[6:0]
// --------------------------------------------------
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011

// --------------------------------------------------
// funct3, insn[14:12]
// --------------------------------------------------
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`endif

// File: rv_exec_pkg.sv
/*
 * Types for the RV64I execute stage
 *   opcode_t    supported major opcodes plus illegal
 *   mem_kind_t  memory access kind of an instruction
 */
`include "rv_exec_consts.svh"

package rv_exec_pkg;

    // Major opcodes handled by this stage
    // Encodings match insn[6:0]
    typedef enum logic [6:0] {
        OPCODE_ILLEGAL = 7'b0000000,
        OPCODE_OP      = `OPC_OP,
        OPCODE_OP_IMM  = `OPC_OP_IMM,
        OPCODE_LUI     = `OPC_LUI,
        OPCODE_AUIPC   = `OPC_AUIPC,
        OPCODE_LOAD    = `OPC_LOAD,
        OPCODE_STORE   = `OPC_STORE
    } opcode_t;

    // Memory access kind
    // None means a register write-back, or nothing at all
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_kind_t;

endpackage

// File: ex_adder.sv
/*
 * 64-bit adder for the ALU
 *   b arrives already inverted for subtraction
 *   sub doubles as the carry-in
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_adder (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic             sub,
    output logic [`XLEN-1:0] result,
    output logic             cout
);

    // One extra bit holds the carry out of the top
    logic [`XLEN:0] sum_ext;

    // a + ~b + 1 gives a - b when sub is set
    assign sum_ext = {1'b0, a} + {1'b0, b} + {{`XLEN{1'b0}}, sub};

    assign result = sum_ext[`XLEN-1:0];
    // Carry out, low means a < b unsigned on subtract
    assign cout   = sum_ext[`XLEN];

endmodule

// File: ex_alu.sv
/*
 * RV64I integer ALU
 *   one-hot operation strobes, AND-OR result mux
 *   shared adder for add, sub and set-less-than
 *   raw adder sum as memory address
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_alu (
    input  logic             op_add,
    input  logic             op_sub,
    input  logic             op_slt,
    input  logic             op_sltu,
    input  logic             op_and,
    input  logic             op_or,
    input  logic             op_xor,
    input  logic             op_sll,
    input  logic             op_srl,
    input  logic             op_sra,
    input  logic [`XLEN-1:0] alu_src1,
    input  logic [`XLEN-1:0] alu_src2,
    output logic [`XLEN-1:0] alu_result,
    output logic [`XLEN-1:0] mem_result
);

    // Shift amount width, 6 bits for RV64
    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] adder_b;
    logic             adder_cin;
    logic [`XLEN-1:0] adder_sum;
    logic             adder_cout;
    logic             slt_bit;
    logic [SHW-1:0]   shamt;
    logic [`XLEN-1:0] r_slt;
    logic [`XLEN-1:0] r_and;
    logic [`XLEN-1:0] r_or;
    logic [`XLEN-1:0] r_xor;
    logic [`XLEN-1:0] r_sll;
    logic [`XLEN-1:0] r_srl;
    logic [`XLEN-1:0] r_sra;

    // --------------------------------------------------
    // Add / subtract
    // --------------------------------------------------
    // Both compares need src1 - src2
    assign adder_cin = op_sub | op_slt | op_sltu;
    assign adder_b   = adder_cin ? ~alu_src2 : alu_src2;

    ex_adder u_adder (
        .a      (alu_src1),
        .b      (adder_b),
        .sub    (adder_cin),
        .result (adder_sum),
        .cout   (adder_cout)
    );

    // Signs differ: src1 negative decides
    // Signs equal: no overflow, sign of difference decides
    assign slt_bit = (alu_src1[`XLEN-1] != alu_src2[`XLEN-1]) ? alu_src1[`XLEN-1]
                                                              : adder_sum[`XLEN-1];
    // Unsigned less-than is a borrow, i.e. no carry out
    assign r_slt   = {{(`XLEN-1){1'b0}}, (op_sltu ? ~adder_cout : slt_bit)};

    // --------------------------------------------------
    // Logic and shifts
    // --------------------------------------------------
    assign r_and = alu_src1 & alu_src2;
    assign r_or  = alu_src1 | alu_src2;
    assign r_xor = alu_src1 ^ alu_src2;

    // Only the low bits of src2 count
    assign shamt = alu_src2[SHW-1:0];
    assign r_sll = alu_src1 << shamt;
    assign r_srl = alu_src1 >> shamt;
    // Arithmetic shift fills with the sign bit
    assign r_sra = $signed(alu_src1) >>> shamt;

    // One-hot strobes, so a plain AND-OR is enough
    assign alu_result = ({`XLEN{op_add | op_sub}}  & adder_sum)
                      | ({`XLEN{op_slt | op_sltu}} & r_slt)
                      | ({`XLEN{op_and}}           & r_and)
                      | ({`XLEN{op_or}}            & r_or)
                      | ({`XLEN{op_xor}}           & r_xor)
                      | ({`XLEN{op_sll}}           & r_sll)
                      | ({`XLEN{op_srl}}           & r_srl)
                      | ({`XLEN{op_sra}}           & r_sra);

    // Address path bypasses the result mux
    assign mem_result = adder_sum;

endmodule

// File: ex_decode.sv
/*
 * Input side of the execute stage
 *   registers instruction, pc and operands
 *   opcode / funct decode into one-hot ALU strobes
 *   immediates, ALU source select, write-back fields
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [`INSN_W-1:0]     insn,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output logic                   op_add,
    output logic                   op_sub,
    output logic                   op_slt,
    output logic                   op_sltu,
    output logic                   op_and,
    output logic                   op_or,
    output logic                   op_xor,
    output logic                   op_sll,
    output logic                   op_srl,
    output logic                   op_sra,
    output logic [`XLEN-1:0]       alu_src1,
    output logic [`XLEN-1:0]       alu_src2,
    output logic                   ex_valid,
    output logic [4:0]             ex_rd,
    output logic                   ex_wen,
    output rv_exec_pkg::mem_kind_t ex_mem_kind,
    output logic [`XLEN-1:0]       ex_store_data
);
    import rv_exec_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic [`INSN_W-1:0] insn_q;
    logic [`XLEN-1:0]   pc_q;
    logic [`XLEN-1:0]   rs1_q;
    logic [`XLEN-1:0]   rs2_q;
    opcode_t            opc;
    logic [2:0]         funct3;
    logic               alt;
    logic               is_shift;
    logic [`XLEN-1:0]   imm_i;
    logic [`XLEN-1:0]   imm_s;
    logic [`XLEN-1:0]   imm_u;
    logic [`XLEN-1:0]   src2_raw;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= in_valid;
        end
    end

    // Payload only loads on a new instruction
    always_ff @(posedge clk) begin
        if (in_valid) begin
            insn_q <= insn;
            pc_q   <= pc;
            rs1_q  <= rs1_data;
            rs2_q  <= rs2_data;
        end
    end

    // --------------------------------------------------
    // Field decode
    // --------------------------------------------------
    always_comb begin
        case (insn_q[6:0])
            `OPC_OP:     opc = OPCODE_OP;
            `OPC_OP_IMM: opc = OPCODE_OP_IMM;
            `OPC_LUI:    opc = OPCODE_LUI;
            `OPC_AUIPC:  opc = OPCODE_AUIPC;
            `OPC_LOAD:   opc = OPCODE_LOAD;
            `OPC_STORE:  opc = OPCODE_STORE;
            default:     opc = OPCODE_ILLEGAL;
        endcase
    end

    assign funct3 = insn_q[14:12];
    // funct7 bit 5 selects sub and sra
    assign alt    = insn_q[30];

    // Sign-extended immediates
    assign imm_i = {{(`XLEN-12){insn_q[31]}}, insn_q[31:20]};
    assign imm_s = {{(`XLEN-12){insn_q[31]}}, insn_q[31:25], insn_q[11:7]};
    assign imm_u = {{(`XLEN-32){insn_q[31]}}, insn_q[31:12], 12'b0};

    // One-hot strobes, all low for illegal opcodes
    always_comb begin
        {op_add, op_sub, op_slt, op_sltu, op_and} = 5'b0;
        {op_or, op_xor, op_sll, op_srl, op_sra}   = 5'b0;
        case (opc)
            OPCODE_OP, OPCODE_OP_IMM: begin
                case (funct3)
                    `F3_ADD: begin
                        // No subtract-immediate in RV64I
                        op_sub = alt && (opc == OPCODE_OP);
                        op_add = !(alt && (opc == OPCODE_OP));
                    end
                    `F3_SLL:  op_sll  = 1'b1;
                    `F3_SLT:  op_slt  = 1'b1;
                    `F3_SLTU: op_sltu = 1'b1;
                    `F3_XOR:  op_xor  = 1'b1;
                    `F3_SR: begin
                        op_sra = alt;
                        op_srl = !alt;
                    end
                    `F3_OR:   op_or   = 1'b1;
                    `F3_AND:  op_and  = 1'b1;
                endcase
            end
            // Address and upper-immediate forms all add
            OPCODE_LUI, OPCODE_AUIPC, OPCODE_LOAD, OPCODE_STORE: op_add = 1'b1;
            default: ;
        endcase
    end

    // --------------------------------------------------
    // ALU sources
    // --------------------------------------------------
    always_comb begin
        case (opc)
            OPCODE_AUIPC: alu_src1 = pc_q;
            OPCODE_LUI:   alu_src1 = '0;
            default:      alu_src1 = rs1_q;
        endcase
    end

    always_comb begin
        case (opc)
            OPCODE_OP:                src2_raw = rs2_q;
            OPCODE_STORE:             src2_raw = imm_s;
            OPCODE_LUI, OPCODE_AUIPC: src2_raw = imm_u;
            default:                  src2_raw = imm_i;
        endcase
    end

    // Shift amount keeps its low six bits only
    assign is_shift = op_sll | op_srl | op_sra;
    assign alu_src2 = is_shift ? {{(`XLEN-SHW){1'b0}}, src2_raw[SHW-1:0]} : src2_raw;

    // --------------------------------------------------
    // Write-back and memory fields
    // --------------------------------------------------
    assign ex_rd  = insn_q[11:7];
    // x0 writes are dropped here
    assign ex_wen = (opc == OPCODE_OP || opc == OPCODE_OP_IMM ||
                     opc == OPCODE_LUI || opc == OPCODE_AUIPC) && (ex_rd != 5'd0);

    always_comb begin
        case (opc)
            OPCODE_LOAD:  ex_mem_kind = MEM_LOAD;
            OPCODE_STORE: ex_mem_kind = MEM_STORE;
            default:      ex_mem_kind = MEM_NONE;
        endcase
    end

    assign ex_store_data = rs2_q;

endmodule

// File: ex_writeback.sv
/*
 * Output side of the execute stage
 *   routes each item to register write-back or memory request
 *   one register stage
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_writeback (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_valid,
    input  logic [4:0]             ex_rd,
    input  logic                   ex_wen,
    input  rv_exec_pkg::mem_kind_t ex_mem_kind,
    input  logic [`XLEN-1:0]       ex_store_data,
    input  logic [`XLEN-1:0]       alu_result,
    input  logic [`XLEN-1:0]       mem_result,
    output logic                   wb_valid,
    output logic [4:0]             wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [`XLEN-1:0]       mem_addr,
    output logic [`XLEN-1:0]       mem_wdata
);
    import rv_exec_pkg::*;

    // Strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
        end else begin
            // Illegal opcodes arrive with wen low and kind none
            wb_valid <= ex_valid && (ex_mem_kind == MEM_NONE) && ex_wen;
            mem_req  <= ex_valid && (ex_mem_kind != MEM_NONE);
            mem_we   <= ex_valid && (ex_mem_kind == MEM_STORE);
        end
    end

    // Payload, held between instructions
    // Load rd rides along for the memory stage
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd     <= ex_rd;
            wb_data   <= alu_result;
            mem_addr  <= mem_result;
            mem_wdata <= ex_store_data;
        end
    end

endmodule

// File: ex_unit_top.sv
/*
 * RV64I execute stage top level
 *   decode -> ALU -> write-back, 2-cycle latency
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [`INSN_W-1:0] insn,
    input  logic [`XLEN-1:0]   pc,
    input  logic [`XLEN-1:0]   rs1_data,
    input  logic [`XLEN-1:0]   rs2_data,
    output logic               wb_valid,
    output logic [4:0]         wb_rd,
    output logic [`XLEN-1:0]   wb_data,
    output logic               mem_req,
    output logic               mem_we,
    output logic [`XLEN-1:0]   mem_addr,
    output logic [`XLEN-1:0]   mem_wdata
);
    import rv_exec_pkg::*;

    // Decode to ALU
    logic             op_add;
    logic             op_sub;
    logic             op_slt;
    logic             op_sltu;
    logic             op_and;
    logic             op_or;
    logic             op_xor;
    logic             op_sll;
    logic             op_srl;
    logic             op_sra;
    logic [`XLEN-1:0] alu_src1;
    logic [`XLEN-1:0] alu_src2;

    // Decode to write-back
    logic             ex_valid;
    logic [4:0]       ex_rd;
    logic             ex_wen;
    mem_kind_t        ex_mem_kind;
    logic [`XLEN-1:0] ex_store_data;

    // ALU to write-back
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] mem_result;

    // --------------------------------------------------
    // Stage 1, registered decode
    // --------------------------------------------------
    ex_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .insn          (insn),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .op_add        (op_add),
        .op_sub        (op_sub),
        .op_slt        (op_slt),
        .op_sltu       (op_sltu),
        .op_and        (op_and),
        .op_or         (op_or),
        .op_xor        (op_xor),
        .op_sll        (op_sll),
        .op_srl        (op_srl),
        .op_sra        (op_sra),
        .alu_src1      (alu_src1),
        .alu_src2      (alu_src2),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_wen        (ex_wen),
        .ex_mem_kind   (ex_mem_kind),
        .ex_store_data (ex_store_data)
    );

    // Combinational ALU between the two register stages
    ex_alu u_alu (
        .op_add     (op_add),
        .op_sub     (op_sub),
        .op_slt     (op_slt),
        .op_sltu    (op_sltu),
        .op_and     (op_and),
        .op_or      (op_or),
        .op_xor     (op_xor),
        .op_sll     (op_sll),
        .op_srl     (op_srl),
        .op_sra     (op_sra),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result),
        .mem_result (mem_result)
    );

    // --------------------------------------------------
    // Stage 2, registered outcome
    // --------------------------------------------------
    ex_writeback u_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex_valid      (ex_valid),
        .ex_rd         (ex_rd),
        .ex_wen        (ex_wen),
        .ex_mem_kind   (ex_mem_kind),
        .ex_store_data (ex_store_data),
        .alu_result    (alu_result),
        .mem_result    (mem_result),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

endmodule

// File: ex_unit_assertions.sv
/*
 * Concurrent assertions for the execute stage
 *   output exclusivity, reset values, 2-cycle latency
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module ex_unit_assertions (
    input logic               clk,
    input logic               rst_n,
    input logic               in_valid,
    input logic [`INSN_W-1:0] insn,
    input logic               wb_valid,
    input logic               mem_req,
    input logic               mem_we
);
    import rv_exec_pkg::*;

    int      fail_count = 0;
    opcode_t opc_in;
    logic    expect_out;

    assign opc_in = opcode_t'(insn[6:0]);
    // Memory ops always show, register ops only with a real rd
    assign expect_out = (opc_in == OPCODE_LOAD) || (opc_in == OPCODE_STORE) ||
                        (((opc_in == OPCODE_OP) || (opc_in == OPCODE_OP_IMM) ||
                          (opc_in == OPCODE_LUI) || (opc_in == OPCODE_AUIPC)) &&
                         (insn[11:7] != 5'd0));

    a_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_req && wb_valid))
        else begin $error("wb_valid and mem_req high together"); fail_count++; end

    a_we: assert property (@(posedge clk) disable iff (!rst_n) mem_we |-> mem_req)
        else begin $error("mem_we without mem_req"); fail_count++; end

    a_reset: assert property (@(posedge clk) !rst_n |=> (!wb_valid && !mem_req && !mem_we))
        else begin $error("outputs valid during reset"); fail_count++; end

    // Legal instruction gives exactly one output two cycles later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(in_valid, 2) && $past(expect_out, 2)) |-> (wb_valid ^ mem_req))
        else begin $error("missing output two cycles after issue"); fail_count++; end

endmodule

bind ex_unit_top ex_unit_assertions u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .insn     (insn),
    .wb_valid (wb_valid),
    .mem_req  (mem_req),
    .mem_we   (mem_we)
);

// File: tb_ex_unit.sv
/*
 * Testbench for the RV64I execute stage
 *   trace-driven stimulus with random idle gaps
 *   2-cycle latency checks against trace expectations
 */
`timescale 1ns/1ps
`include "rv_exec_consts.svh"

module tb_ex_unit;

    // Trace layout of 8 words per entry
    localparam int MAX_ENTRIES = 32;
    localparam int COLS        = 8;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic [`INSN_W-1:0] insn;
    logic [`XLEN-1:0]   pc;
    logic [`XLEN-1:0]   rs1_data;
    logic [`XLEN-1:0]   rs2_data;
    logic               wb_valid;
    logic [4:0]         wb_rd;
    logic [`XLEN-1:0]   wb_data;
    logic               mem_req;
    logic               mem_we;
    logic [`XLEN-1:0]   mem_addr;
    logic [`XLEN-1:0]   mem_wdata;

    logic [63:0] trace_mem [0:MAX_ENTRIES*COLS-1];
    int          num_entries;
    int          cur_idx;
    int          outstanding;
    int          cycles;
    int          cycle_limit;
    int          in_flight[$];
    logic [31:0] rnd_state;

    ex_unit_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .insn      (insn),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    // Xorshift32 step
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // --------------------------------------------------
    // Timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout, outputs did not arrive within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Failures counted by the bound checker
    always @(negedge clk) begin
        if (dut0.u_assert.fail_count != 0) begin
            $display("Assertion failed in the bound checker at %0t", $time);
            $display("Errors found");
            $fatal(1);
        end
    end

    // --------------------------------------------------
    // Output monitor sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        int idx;
        int base;
        if (rst_n) begin
            in_flight.push_back(in_valid ? cur_idx : -1);
            if (in_valid) outstanding++;
            if (in_flight.size() > 2) begin
                idx = in_flight.pop_front();
                base = idx * COLS;
                // Kind 0 none, 1 write-back, 2 load, 3 store
                if (idx < 0 || trace_mem[base+4][1:0] == 2'd0) begin
                    check_value("wb_valid", {63'b0, wb_valid}, 64'd0);
                    check_value("mem_req", {63'b0, mem_req}, 64'd0);
                end else if (trace_mem[base+4][1:0] == 2'd1) begin
                    check_value("wb_valid", {63'b0, wb_valid}, 64'd1);
                    check_value("mem_req", {63'b0, mem_req}, 64'd0);
                    check_value("wb_rd", {59'b0, wb_rd}, {59'b0, trace_mem[base+5][4:0]});
                    check_value("wb_data", wb_data, trace_mem[base+6]);
                end else begin
                    check_value("wb_valid", {63'b0, wb_valid}, 64'd0);
                    check_value("mem_req", {63'b0, mem_req}, 64'd1);
                    check_value("mem_addr", mem_addr, trace_mem[base+6]);
                    if (trace_mem[base+4][1:0] == 2'd2) begin
                        check_value("mem_we", {63'b0, mem_we}, 64'd0);
                        check_value("wb_rd", {59'b0, wb_rd}, {59'b0, trace_mem[base+5][4:0]});
                    end else begin
                        check_value("mem_we", {63'b0, mem_we}, 64'd1);
                        check_value("mem_wdata", mem_wdata, trace_mem[base+7]);
                    end
                end
                if (idx >= 0) outstanding--;
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int gap;
        int base;
        clk         = 1'b0;
        cycles      = 0;
        cycle_limit = 1000;
        outstanding = 0;
        num_entries = 0;
        rnd_state   = 32'd50;
        cur_idx  <= -1;
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        insn     <= '0;
        pc       <= '0;
        rs1_data <= '0;
        rs2_data <= '0;

        // Sentinel fill marks unused entries by their upper bits
        for (int a = 0; a < MAX_ENTRIES*COLS; a++) begin
            trace_mem[a] = {32'hFFFF_FFFF, 32'(a)};
        end
        $readmemh("ex_trace.txt", trace_mem);
        while (num_entries < MAX_ENTRIES && trace_mem[num_entries*COLS][63:32] == 32'd0) begin
            num_entries++;
        end
        cycle_limit = 3 * num_entries + 20;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < num_entries; i++) begin
            rnd_state = xorshift(rnd_state);
            gap = int'(rnd_state % 32'd3);
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            base = i * COLS;
            @(posedge clk);
            in_valid <= 1'b1;
            cur_idx  <= i;
            insn     <= trace_mem[base][31:0];
            pc       <= trace_mem[base+1];
            rs1_data <= trace_mem[base+2];
            rs2_data <= trace_mem[base+3];
        end
        @(posedge clk);
        in_valid <= 1'b0;

        // Drain the pipeline
        while (outstanding != 0) @(posedge clk);
        repeat (2) @(posedge clk);

        if (dut0.u_assert.fail_count != 0) begin
            $display("Assertion failures: %0d", dut0.u_assert.fail_count);
            $display("Errors found");
            $fatal(1);
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: ex_trace.txt
// insn pc rs1_data rs2_data kind(0 none,1 wb,2 load,3 store) rd value_or_addr store_data
// add sub and or xor addi xori slt sltu sll srl sra slli srai lui auipc ld sd add-x0 illegal
002081B3 0 FFFFFFFFFFFFFFFF 2 1 3 1 0
40208233 0 0 1 1 4 FFFFFFFFFFFFFFFF 0
0020F2B3 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 1 5 F000F000F000F000 0
0020E333 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 1 6 FFF0FFF0FFF0FFF0 0
0020C3B3 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 1 7 0FF00FF00FF00FF0 0
FFF08413 0 5 0 1 8 4 0
0FF0C493 0 F0 0 1 9 F 0
0020A533 0 8000000000000001 1 1 A 1 0
0020B5B3 0 8000000000000001 1 1 B 0 0
00209633 0 1 3F 1 C 8000000000000000 0
0020D6B3 0 8000000000000000 41 1 D 4000000000000000 0
4020D733 0 8000000000000000 3F 1 E FFFFFFFFFFFFFFFF 0
00009793 0 123 0 1 F 123 0
4010D813 0 FFFFFFFFFFFFFFF0 0 1 10 FFFFFFFFFFFFFFF8 0
800008B7 0 0 0 1 11 FFFFFFFF80000000 0
00001917 1000 0 0 1 12 2000 0
FF80B983 0 100 0 2 13 F8 0
0020B823 0 200 DEADBEEFCAFEF00D 3 10 210 DEADBEEFCAFEF00D
00208033 0 5 6 0 0 0 0
0000007F 0 5 6 0 0 0 0

// File: list.f
+incdir+.
rv_exec_pkg.sv
ex_adder.sv
ex_alu.sv
ex_decode.sv
ex_writeback.sv
ex_unit_top.sv
ex_unit_assertions.sv
tb_ex_unit.sv

// File: Makefile
TOP = tb_ex_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
